// File: all.f
+incdir+.
carrierLoopPkg.sv
loopRegs.sv
loopFilter.sv
lockDetector.sv
carrierNco.sv
complexMixer.sv
trellisCarrierLoop.sv
tbTrellisCarrierLoop.sv

// File: carrierLoopPkg.sv
//--------------------------------------------------------------------------
// Shared types of the carrier recovery loop: the I/Q sample and host bus
// structs, the loop control fields, the register offsets and the lock
// detector states. Modules take what they need by a wildcard import.
//--------------------------------------------------------------------------
`default_nettype none

package carrierLoopPkg;

  // Default sample width, also sets the width of the iqSample_t fields
  localparam int SAMPLE_WIDTH = 18;

  typedef struct packed {
    logic signed [SAMPLE_WIDTH-1:0] i;
    logic signed [SAMPLE_WIDTH-1:0] q;
  } iqSample_t;

  // Host write side, one strobe per byte lane
  typedef struct packed {
    logic [11:0] addr;
    logic [3:0]  wrEn;
    logic [31:0] din;
  } regBus_t;

  typedef struct packed {
    logic        invertError;
    logic        zeroError;
    logic        clearAccum;
    logic [4:0]  leadExp;
    logic [4:0]  lagExp;
    logic [31:0] limit;
    logic [15:0] lockCount;
    logic [7:0]  syncThreshold;
  } loopCtrl_t;

  // Byte offsets inside the register window
  typedef enum logic [4:0] {
    CTRL   = 5'h00,
    GAINS  = 5'h04,
    LIMIT  = 5'h08,
    LOCK   = 5'h0C,
    LAGACC = 5'h10,
    STATUS = 5'h14
  } regOffset_e;

  typedef enum logic {
    UNLOCKED = 1'b0,
    LOCKED   = 1'b1
  } lockState_e;

endpackage

`default_nettype wire

// File: carrierNco.sv
//--------------------------------------------------------------------------
// Carrier NCO. A 32-bit phase accumulator steps by the frequency word
// every clock. The top 8 phase bits index a folded quarter-wave table, and
// cosine/sine come out 2 cycles after the phase.
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module carrierNco
  import carrierLoopPkg::*;
#(
  parameter int SAMPLE_WIDTH = 18
)(
  input  logic        clk,
  input  logic        reset,
  input  logic [31:0] freqWord,
  output iqSample_t   lo
);

  `include "ncoTable.svh"

  logic [31:0]                    phase;
  logic [5:0]                     fine;
  logic [5:0]                     sinIdx;
  logic [1:0]                     quadrant;
  logic [16:0]                    cosMag;
  logic [16:0]                    sinMag;
  logic signed [SAMPLE_WIDTH-1:0] cosVal;
  logic signed [SAMPLE_WIDTH-1:0] sinVal;

  always_ff @(posedge clk) begin
    if (reset) begin
      phase <= '0;
    end else begin
      phase <= phase + freqWord;
    end
  end

  // Sine of the fine angle is the cosine mirrored at a quarter turn
  assign fine   = phase[29:24];
  assign sinIdx = 6'd0 - fine;

  always_ff @(posedge clk) begin
    quadrant <= phase[31:30];
    cosMag   <= COS_QUARTER[fine];
    sinMag   <= (fine == 6'd0) ? 17'd0 : COS_QUARTER[sinIdx];
  end

  assign cosVal = SAMPLE_WIDTH'(cosMag);
  assign sinVal = SAMPLE_WIDTH'(sinMag);

  // Rotate by the quadrant
  always_ff @(posedge clk) begin
    case (quadrant)
      2'd0: begin
        lo.i <= cosVal;
        lo.q <= sinVal;
      end
      2'd1: begin
        lo.i <= -sinVal;
        lo.q <= cosVal;
      end
      2'd2: begin
        lo.i <= -cosVal;
        lo.q <= -sinVal;
      end
      default: begin
        lo.i <= sinVal;
        lo.q <= -cosVal;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: complexMixer.sv
//--------------------------------------------------------------------------
// Complex mixer. Rotates each input sample by the NCO pair in a 4-stage
// pipeline: input registers, products, sum and difference, then rounding
// and saturation back to the sample width. Takes a sample every clock.
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module complexMixer
  import carrierLoopPkg::*;
#(
  parameter int SAMPLE_WIDTH = 18
)(
  input  logic      clk,
  input  logic      reset,
  input  iqSample_t iqIn,
  input  iqSample_t lo,
  output iqSample_t iqOut
);

  localparam int PROD_WIDTH = 2 * SAMPLE_WIDTH;
  localparam int SUM_WIDTH  = PROD_WIDTH + 1;
  localparam int SHIFT      = SAMPLE_WIDTH - 1;
  localparam int RES_WIDTH  = SUM_WIDTH - SHIFT;
  localparam logic signed [SUM_WIDTH-1:0] ROUND   = SUM_WIDTH'(1) <<< (SHIFT - 1);
  localparam logic signed [RES_WIDTH-1:0] SAT_MAX = RES_WIDTH'((1 <<< SHIFT) - 1);
  localparam logic signed [RES_WIDTH-1:0] SAT_MIN = -SAT_MAX - 1;

  logic signed [SAMPLE_WIDTH-1:0] aI;
  logic signed [SAMPLE_WIDTH-1:0] aQ;
  logic signed [SAMPLE_WIDTH-1:0] bI;
  logic signed [SAMPLE_WIDTH-1:0] bQ;
  logic signed [PROD_WIDTH-1:0]   pII;
  logic signed [PROD_WIDTH-1:0]   pQQ;
  logic signed [PROD_WIDTH-1:0]   pIQ;
  logic signed [PROD_WIDTH-1:0]   pQI;
  logic signed [SUM_WIDTH-1:0]    sumI;
  logic signed [SUM_WIDTH-1:0]    sumQ;

  // Round half up, drop SHIFT bits, clip to the sample range
  function automatic logic signed [SAMPLE_WIDTH-1:0] roundSat(
    input logic signed [SUM_WIDTH-1:0] x
  );
    logic signed [SUM_WIDTH-1:0] biased;
    logic signed [RES_WIDTH-1:0] scaled;
    biased = x + ROUND;
    scaled = RES_WIDTH'(biased >>> SHIFT);
    if (scaled > SAT_MAX) begin
      return SAT_MAX[SAMPLE_WIDTH-1:0];
    end else if (scaled < SAT_MIN) begin
      return SAT_MIN[SAMPLE_WIDTH-1:0];
    end
    return scaled[SAMPLE_WIDTH-1:0];
  endfunction

  always_ff @(posedge clk) begin
    if (reset) begin
      {aI, aQ, bI, bQ}     <= '0;
      {pII, pQQ, pIQ, pQI} <= '0;
      {sumI, sumQ}         <= '0;
      iqOut                <= '0;
    end else begin
      aI    <= $signed(iqIn.i);
      aQ    <= $signed(iqIn.q);
      bI    <= $signed(lo.i);
      bQ    <= $signed(lo.q);
      pII   <= aI * bI;
      pQQ   <= aQ * bQ;
      pIQ   <= aI * bQ;
      pQI   <= aQ * bI;
      sumI  <= pII - pQQ;
      sumQ  <= pIQ + pQI;
      iqOut.i <= roundSat(sumI);
      iqOut.q <= roundSat(sumQ);
    end
  end

endmodule

`default_nettype wire

// File: lockDetector.sv
//--------------------------------------------------------------------------
// Carrier lock detector. An up/down counter of symbol quality runs on each
// errEn strobe, and its overflow or underflow sets or clears the lock.
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module lockDetector
  import carrierLoopPkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              errEn,
  input  logic signed [7:0] phaseError,
  input  logic [7:0]        syncThreshold,
  input  logic [15:0]       lockCount,
  output logic              carrierLock,
  output logic [15:0]       lockCounter
);

  lockState_e  lockState;
  logic [7:0]  absError;
  logic [16:0] lockPlus;
  logic [16:0] lockMinus;

  // Magnitude of the raw error, -128 maps to 0x80
  assign absError  = phaseError[7] ? 8'(-phaseError) : 8'(phaseError);
  assign lockPlus  = {1'b0, lockCounter} + 17'd1;
  assign lockMinus = {1'b0, lockCounter} - 17'd1;

  always_ff @(posedge clk) begin
    if (reset) begin
      lockCounter <= '0;
      lockState   <= UNLOCKED;
    end else if (errEn) begin
      if (absError > syncThreshold) begin
        // Bad symbol, underflow drops the lock
        if (lockMinus[16]) begin
          lockCounter <= lockCount;
          lockState   <= UNLOCKED;
        end else begin
          lockCounter <= lockMinus[15:0];
        end
      end else if (lockPlus[16]) begin
        lockCounter <= lockCount;
        lockState   <= LOCKED;
      end else begin
        lockCounter <= lockPlus[15:0];
      end
    end
  end

  assign carrierLock = (lockState == LOCKED);

endmodule

`default_nettype wire

// File: loopFilter.sv
//--------------------------------------------------------------------------
// Loop filter of the carrier loop. Adjusts the phase error, then runs the
// lead path and the limited lag accumulator on each errEn strobe. The sum
// gives the frequency word, loaded one clock after the strobe.
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module loopFilter
  import carrierLoopPkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              errEn,
  input  logic signed [7:0] phaseError,
  input  loopCtrl_t         ctrl,
  output logic [39:0]       lagAccum,
  output logic [31:0]       freqWord
);

  logic signed [7:0]  loopError;
  logic signed [39:0] errExt;
  logic signed [39:0] leadError;
  logic signed [39:0] lagStep;
  logic signed [39:0] lagSum;
  logic signed [31:0] lagTop;
  logic signed [31:0] posLimit;
  logic signed [31:0] negLimit;
  logic [39:0]        lagNext;
  logic [39:0]        filterSum;
  logic               errEnDly;

  // Error adjust, e(k) registered on the strobe
  always_ff @(posedge clk) begin
    if (reset) begin
      loopError <= '0;
    end else if (errEn) begin
      if (ctrl.zeroError) begin
        loopError <= '0;
      end else if (ctrl.invertError) begin
        loopError <= -phaseError;
      end else begin
        loopError <= phaseError;
      end
    end
  end

  //--------------------------------------------------------------------------
  // Lead and lag gains are plain shifts of e(k-1)
  //--------------------------------------------------------------------------
  assign errExt    = {{32{loopError[7]}}, loopError};
  assign leadError = errExt <<< ctrl.leadExp;
  assign lagStep   = errExt <<< ctrl.lagExp;
  assign lagSum    = $signed(lagAccum) + lagStep;
  assign lagTop    = lagSum[39:8];
  assign posLimit  = ctrl.limit;
  assign negLimit  = -posLimit;

  // Symmetric clamp on the top 32 bits
  always_comb begin
    if (ctrl.clearAccum) begin
      lagNext = '0;
    end else if (lagTop > posLimit) begin
      lagNext = {posLimit, 8'h00};
    end else if (lagTop < negLimit) begin
      lagNext = {negLimit, 8'h00};
    end else begin
      lagNext = lagSum;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      lagAccum  <= '0;
      filterSum <= '0;
      errEnDly  <= 1'b0;
      freqWord  <= '0;
    end else begin
      errEnDly <= errEn;
      if (errEn) begin
        lagAccum  <= lagNext;
        filterSum <= lagAccum + leadError;
      end
      if (errEnDly) begin
        freqWord <= filterSum[39:8];
      end
    end
  end

  aLagWithinLimit: assert property (@(posedge clk) disable iff (reset)
    errEn && !ctrl.limit[31] |=>
      ($signed(lagAccum[39:8]) <= $signed($past(ctrl.limit))) &&
      ($signed(lagAccum[39:8]) >= -$signed($past(ctrl.limit))))
    else $error("lag accumulator beyond limit");

endmodule

`default_nettype wire

// File: loopRegs.sv
//--------------------------------------------------------------------------
// Host register block of the carrier loop. Decodes its own 32 byte window,
// takes byte-lane writes and muxes the readback of controls and status.
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module loopRegs
  import carrierLoopPkg::*;
#(
  parameter logic [11:0] BASE_ADDR = 12'h400
)(
  input  logic        clk,
  input  logic        reset,
  input  regBus_t     bus,
  input  logic [31:0] lagAccum,
  input  logic [15:0] lockCounter,
  input  logic        carrierLock,
  output loopCtrl_t   ctrl,
  output logic [31:0] dout
);

  localparam loopCtrl_t CTRL_RESET = '{
    invertError: 1'b0, zeroError: 1'b0, clearAccum: 1'b0,
    leadExp: 5'd0, lagExp: 5'd0, limit: 32'h7FFF_FFFF,
    lockCount: 16'h0000, syncThreshold: 8'h20
  };

  logic        inBlock;
  logic        wrHit;
  logic [4:0]  offset;
  logic [31:0] curWord;
  logic [31:0] newWord;

  // Upper 7 address bits select the block
  assign inBlock = (bus.addr[11:5] == BASE_ADDR[11:5]);
  assign wrHit   = inBlock && (bus.wrEn != 4'b0000);
  assign offset  = {bus.addr[4:2], 2'b00};

  always_comb begin
    case (offset)
      CTRL:    curWord = {29'd0, ctrl.clearAccum, ctrl.zeroError, ctrl.invertError};
      GAINS:   curWord = {19'd0, ctrl.lagExp, 3'd0, ctrl.leadExp};
      LIMIT:   curWord = ctrl.limit;
      LOCK:    curWord = {8'd0, ctrl.syncThreshold, ctrl.lockCount};
      LAGACC:  curWord = lagAccum;
      STATUS:  curWord = {15'd0, carrierLock, lockCounter};
      default: curWord = 32'd0;
    endcase
  end

  assign dout = inBlock ? curWord : 32'd0;

  // Merge the written lanes into the current word
  always_comb begin
    for (int b = 0; b < 4; b++) begin
      newWord[8*b +: 8] = bus.wrEn[b] ? bus.din[8*b +: 8] : curWord[8*b +: 8];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ctrl <= CTRL_RESET;
    end else if (wrHit) begin
      case (offset)
        CTRL: begin
          ctrl.invertError <= newWord[0];
          ctrl.zeroError   <= newWord[1];
          ctrl.clearAccum  <= newWord[2];
        end
        GAINS: begin
          ctrl.leadExp <= newWord[4:0];
          ctrl.lagExp  <= newWord[12:8];
        end
        LIMIT: ctrl.limit <= newWord;
        LOCK: begin
          ctrl.lockCount     <= newWord[15:0];
          ctrl.syncThreshold <= newWord[23:16];
        end
        default: ;
      endcase
    end
  end

  // Writes to LAGACC or STATUS must leave every control untouched
  aNoReadOnlyWrite: assert property (@(posedge clk) disable iff (reset)
    wrHit && (offset == LAGACC || offset == STATUS) |=> $stable(ctrl))
    else $error("write reached a read-only register");

endmodule

`default_nettype wire

// File: ncoTable.svh
//--------------------------------------------------------------------------
// Quarter-wave cosine table for the carrier NCO, included inside the
// oscillator module. Entry n holds cos(2*pi*n/256) at a full scale of
// 2^17-1, for n from 0 to 63.
//--------------------------------------------------------------------------
`ifndef NCO_TABLE_SVH
`define NCO_TABLE_SVH

localparam logic [16:0] COS_QUARTER [0:63] = '{
  17'd131071, 17'd131032, 17'd130913, 17'd130716,
  17'd130440, 17'd130085, 17'd129652, 17'd129141,
  17'd128553, 17'd127886, 17'd127143, 17'd126323,
  17'd125427, 17'd124456, 17'd123409, 17'd122288,
  17'd121094, 17'd119826, 17'd118487, 17'd117076,
  17'd115594, 17'd114043, 17'd112423, 17'd110736,
  17'd108982, 17'd107162, 17'd105277, 17'd103329,
  17'd101319, 17'd99248,  17'd97117,  17'd94928,
  17'd92681,  17'd90379,  17'd88022,  17'd85612,
  17'd83151,  17'd80639,  17'd78079,  17'd75472,
  17'd72819,  17'd70123,  17'd67384,  17'd64605,
  17'd61786,  17'd58931,  17'd56040,  17'd53115,
  17'd50159,  17'd47172,  17'd44156,  17'd41115,
  17'd38048,  17'd34958,  17'd31848,  17'd28718,
  17'd25571,  17'd22408,  17'd19232,  17'd16044,
  17'd12847,  17'd9642,   17'd6431,   17'd3217
};

`endif

// File: runSim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module tbTrellisCarrierLoop -f all.f

simOut=$(./obj_dir/VtbTrellisCarrierLoop) || true
printf '%s\n' "$simOut"

if printf '%s\n' "$simOut" | grep -qF '*** TEST PASSED ***'; then
  exit 0
fi
exit 1

// File: tbTrellisCarrierLoop.sv
//----------------------------------------------------------------------------
// Testbench of the carrier recovery loop. Runs a table of register, phase
// error and mixer steps against the DUT. A model of the error pipeline,
// the lag accumulator and the lock counter predicts the readback.
//----------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tbTrellisCarrierLoop
  import carrierLoopPkg::*;
();

  localparam logic [11:0] BASE_ADDR = 12'h400;
  localparam logic [11:0] A_CTRL    = BASE_ADDR + 12'(CTRL);
  localparam logic [11:0] A_GAINS   = BASE_ADDR + 12'(GAINS);
  localparam logic [11:0] A_LIMIT   = BASE_ADDR + 12'(LIMIT);
  localparam logic [11:0] A_LOCK    = BASE_ADDR + 12'(LOCK);
  localparam logic [11:0] A_LAGACC  = BASE_ADDR + 12'(LAGACC);
  localparam logic [11:0] A_STATUS  = BASE_ADDR + 12'(STATUS);
  // Entry 0 of the quarter-wave cosine table
  localparam longint FULL_SCALE = 131071;

  typedef enum logic [2:0] {
    OP_IDLE, OP_WRITE, OP_READ, OP_RESET, OP_ERR, OP_RANDERR, OP_MIX, OP_WAITLOCK
  } opType_e;

  typedef struct packed {
    opType_e     op;
    logic [11:0] addr;
    logic [3:0]  lanes;
    logic [31:0] data;
    logic [31:0] expVal;
    logic [31:0] count;
  } step_t;

  localparam int NUM_STEPS = 51;
  localparam step_t STEPS [NUM_STEPS] = '{
    '{OP_IDLE,     12'h000,  4'h0,    32'h0,           32'h0,           32'd0},
    // Byte-lane writes merge with the reset values
    '{OP_WRITE,    A_GAINS,  4'b0010, 32'h0000_0304,   32'h0,           32'd0},
    '{OP_READ,     A_GAINS,  4'h0,    32'h0,           32'h0000_0300,   32'd0},
    '{OP_WRITE,    A_LOCK,   4'b0100, 32'h0055_1234,   32'h0,           32'd0},
    '{OP_READ,     A_LOCK,   4'h0,    32'h0,           32'h0055_0000,   32'd0},
    '{OP_WRITE,    A_LIMIT,  4'b0001, 32'h0000_00AB,   32'h0,           32'd0},
    '{OP_READ,     A_LIMIT,  4'h0,    32'h0,           32'h7FFF_FFAB,   32'd0},
    '{OP_WRITE,    A_LIMIT,  4'b1000, 32'h1200_0000,   32'h0,           32'd0},
    '{OP_READ,     A_LIMIT,  4'h0,    32'h0,           32'h12FF_FFAB,   32'd0},
    '{OP_WRITE,    A_CTRL,   4'b0010, 32'hFFFF_FFFF,   32'h0,           32'd0},
    '{OP_READ,     A_CTRL,   4'h0,    32'h0,           32'h0,           32'd0},
    '{OP_WRITE,    A_STATUS, 4'b1111, 32'hFFFF_FFFF,   32'h0,           32'd0},
    '{OP_READ,     A_STATUS, 4'h0,    32'h0,           32'h0,           32'd0},
    '{OP_READ,     A_LAGACC, 4'h0,    32'h0,           32'h0,           32'd0},
    '{OP_WRITE,    12'h800,  4'b1111, 32'h0000_0007,   32'h0,           32'd0},
    '{OP_READ,     A_CTRL,   4'h0,    32'h0,           32'h0,           32'd0},
    '{OP_READ,     12'h418,  4'h0,    32'h0,           32'h0,           32'd0},
    '{OP_READ,     12'h420,  4'h0,    32'h0,           32'h0,           32'd0},
    // Mixer with the NCO parked at phase zero
    '{OP_MIX,      12'h000,  4'h0,    32'h0,           32'h0,           32'd48},
    // Lag accumulation, inversion, freeze and clear
    '{OP_WRITE,    A_GAINS,  4'b1111, 32'h0000_0400,   32'h0,           32'd0},
    '{OP_WRITE,    A_LIMIT,  4'b1111, 32'h7FFF_FFFF,   32'h0,           32'd0},
    '{OP_RANDERR,  12'h000,  4'h0,    32'h0,           32'h0,           32'd24},
    '{OP_WRITE,    A_CTRL,   4'b0001, 32'h0000_0001,   32'h0,           32'd0},
    '{OP_RANDERR,  12'h000,  4'h0,    32'h0,           32'h0,           32'd24},
    '{OP_WRITE,    A_CTRL,   4'b0001, 32'h0000_0002,   32'h0,           32'd0},
    '{OP_ERR,      12'h000,  4'h0,    32'h0000_0030,   32'h0,           32'd4},
    '{OP_WRITE,    A_CTRL,   4'b0001, 32'h0000_0004,   32'h0,           32'd0},
    '{OP_ERR,      12'h000,  4'h0,    32'h0000_0030,   32'h0,           32'd2},
    '{OP_READ,     A_LAGACC, 4'h0,    32'h0,           32'h0,           32'd0},
    // Saturation at a small limit, both signs
    '{OP_WRITE,    A_CTRL,   4'b0001, 32'h0000_0000,   32'h0,           32'd0},
    '{OP_WRITE,    A_LIMIT,  4'b1111, 32'h0000_0100,   32'h0,           32'd0},
    '{OP_WRITE,    A_GAINS,  4'b1111, 32'h0000_0800,   32'h0,           32'd0},
    '{OP_ERR,      12'h000,  4'h0,    32'h0000_007F,   32'h0,           32'd8},
    '{OP_READ,     A_LAGACC, 4'h0,    32'h0,           32'h0000_0100,   32'd0},
    '{OP_WRITE,    A_CTRL,   4'b0001, 32'h0000_0001,   32'h0,           32'd0},
    '{OP_ERR,      12'h000,  4'h0,    32'h0000_007F,   32'h0,           32'd8},
    '{OP_READ,     A_LAGACC, 4'h0,    32'h0,           32'hFFFF_FF00,   32'd0},
    // Lock sequence from a fresh reset
    '{OP_RESET,    12'h000,  4'h0,    32'h0,           32'h0,           32'd0},
    '{OP_IDLE,     12'h000,  4'h0,    32'h0,           32'h0,           32'd0},
    '{OP_WRITE,    A_LOCK,   4'b1111, 32'h0010_FFF0,   32'h0,           32'd0},
    '{OP_ERR,      12'h000,  4'h0,    32'h0000_0040,   32'h0,           32'd1},
    '{OP_READ,     A_STATUS, 4'h0,    32'h0,           32'h0000_FFF0,   32'd0},
    '{OP_ERR,      12'h000,  4'h0,    32'h0000_0010,   32'h0,           32'd8},
    '{OP_ERR,      12'h000,  4'h0,    32'h0000_00F0,   32'h0,           32'd8},
    '{OP_WAITLOCK, 12'h000,  4'h0,    32'h0000_0001,   32'h0,           32'd8},
    '{OP_READ,     A_STATUS, 4'h0,    32'h0,           32'h0001_FFF0,   32'd0},
    '{OP_ERR,      12'h000,  4'h0,    32'h0000_00C0,   32'h0,           32'h0000_FFF0},
    '{OP_READ,     A_STATUS, 4'h0,    32'h0,           32'h0001_0000,   32'd0},
    '{OP_ERR,      12'h000,  4'h0,    32'h0000_00C0,   32'h0,           32'd1},
    '{OP_WAITLOCK, 12'h000,  4'h0,    32'h0000_0000,   32'h0,           32'd8},
    '{OP_READ,     A_STATUS, 4'h0,    32'h0,           32'h0000_FFF0,   32'd0}
  };

  logic              clk;
  logic              reset;
  logic              symEn;
  logic              sym2xEn;
  logic              errEn;
  logic signed [7:0] phaseError;
  iqSample_t         iqIn;
  regBus_t           bus;
  logic [31:0]       dout;
  iqSample_t         iqOut;
  logic              carrierLock;
  logic              symEnDly;
  logic              sym2xEnDly;

  // Model state, register shadow indexed by word offset
  logic [31:0]        shadow [0:3];
  logic signed [39:0] mdlLag;
  logic signed [7:0]  mdlPrevErr;
  logic [15:0]        mdlCount;
  logic               mdlLock;
  logic [31:0]        rngState;

  trellisCarrierLoop #(.BASE_ADDR(BASE_ADDR), .SAMPLE_WIDTH(SAMPLE_WIDTH)) u_trellisCarrierLoop (
    .clk, .reset, .symEn, .sym2xEn, .errEn, .phaseError, .iqIn, .bus,
    .dout, .iqOut, .carrierLock, .symEnDly, .sym2xEnDly
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //--------------------------------------------------------------------------
  // Failure reporting
  //--------------------------------------------------------------------------
  task automatic valueError(input string msg);
    $display("[ERROR] %0t ns: %s", $time, msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopped at the first wrong value");
  endtask

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "run aborted");
  endtask

  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Rotation by the parked NCO, rounded half up
  function automatic logic signed [SAMPLE_WIDTH-1:0] mixScale(
    input logic signed [SAMPLE_WIDTH-1:0] x
  );
    longint p;
    p = longint'(x) * FULL_SCALE + (longint'(1) <<< (SAMPLE_WIDTH - 2));
    p = p >>> (SAMPLE_WIDTH - 1);
    if (p > FULL_SCALE) begin
      p = FULL_SCALE;
    end else if (p < -FULL_SCALE - 1) begin
      p = -FULL_SCALE - 1;
    end
    return p[SAMPLE_WIDTH-1:0];
  endfunction

  //--------------------------------------------------------------------------
  // Reference model
  //--------------------------------------------------------------------------
  task automatic resetModel();
    shadow[0]  = 32'h0000_0000;
    shadow[1]  = 32'h0000_0000;
    shadow[2]  = 32'h7FFF_FFFF;
    shadow[3]  = 32'h0020_0000;
    mdlLag     = '0;
    mdlPrevErr = '0;
    mdlCount   = '0;
    mdlLock    = 1'b0;
  endtask

  // Only the four writable words inside the window take a write
  task automatic trackWrite(input logic [11:0] regAddr, input logic [3:0] lanes,
                            input logic [31:0] wdata);
    logic [31:0] mask;
    int          idx;
    idx = int'(regAddr[3:2]);
    case (idx)
      0:       mask = 32'h0000_0007;
      1:       mask = 32'h0000_1F1F;
      2:       mask = 32'hFFFF_FFFF;
      default: mask = 32'h00FF_FFFF;
    endcase
    if (regAddr[11:5] == BASE_ADDR[11:5] && !regAddr[4]) begin
      for (int b = 0; b < 4; b++) begin
        if (lanes[b]) begin
          shadow[idx][8*b +: 8] = wdata[8*b +: 8] & mask[8*b +: 8];
        end
      end
    end
  endtask

  task automatic updateModel(input logic signed [7:0] pe);
    logic signed [39:0] step;
    logic signed [39:0] sum;
    logic signed [31:0] top;
    logic signed [31:0] lim;
    int                 mag;
    lim  = shadow[2];
    step = 40'(mdlPrevErr);
    step = step <<< shadow[1][12:8];
    sum  = mdlLag + step;
    top  = sum[39:8];
    if (shadow[0][2]) begin
      mdlLag = '0;
    end else if (top > lim) begin
      mdlLag = {lim, 8'h00};
    end else if (top < -lim) begin
      mdlLag = {-lim, 8'h00};
    end else begin
      mdlLag = sum;
    end
    // e(k) for the next strobe
    if (shadow[0][1]) begin
      mdlPrevErr = '0;
    end else if (shadow[0][0]) begin
      mdlPrevErr = -pe;
    end else begin
      mdlPrevErr = pe;
    end
    mag = pe;
    if (mag < 0) begin
      mag = -mag;
    end
    if (mag > int'(shadow[3][23:16])) begin
      if (mdlCount == 16'h0000) begin
        mdlCount = shadow[3][15:0];
        mdlLock  = 1'b0;
      end else begin
        mdlCount = mdlCount - 16'd1;
      end
    end else if (mdlCount == 16'hFFFF) begin
      mdlCount = shadow[3][15:0];
      mdlLock  = 1'b1;
    end else begin
      mdlCount = mdlCount + 16'd1;
    end
  endtask

  //--------------------------------------------------------------------------
  // Bus and stimulus tasks
  //--------------------------------------------------------------------------
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic applyReset();
    reset      = 1'b1;
    symEn      = 1'b0;
    sym2xEn    = 1'b0;
    errEn      = 1'b0;
    phaseError = '0;
    iqIn       = '0;
    bus        = '0;
    repeat (4) tick();
    reset = 1'b0;
    resetModel();
  endtask

  task automatic writeReg(input logic [11:0] regAddr, input logic [3:0] lanes,
                          input logic [31:0] wdata);
    tick();
    bus = '{addr: regAddr, wrEn: lanes, din: wdata};
    tick();
    bus.wrEn = 4'b0000;
    trackWrite(regAddr, lanes, wdata);
  endtask

  // dout follows addr without a clock
  task automatic checkRead(input logic [11:0] regAddr, input logic [31:0] expVal);
    logic [31:0] data;
    tick();
    bus.addr = regAddr;
    bus.wrEn = 4'b0000;
    #1;
    data = dout;
    assert (data == expVal)
      else valueError($sformatf("read 0x%03h gave 0x%08h, expected 0x%08h",
                                regAddr, data, expVal));
  endtask

  task automatic checkModel();
    checkRead(A_LAGACC, mdlLag[39:8]);
    checkRead(A_STATUS, {15'd0, mdlLock, mdlCount});
  endtask

  task automatic checkIdle();
    assert (carrierLock === 1'b0 && symEnDly === 1'b0 && sym2xEnDly === 1'b0 &&
            iqOut === '0)
      else valueError($sformatf("outputs after reset: lock %b symDly %b sym2xDly %b iq %h",
                                carrierLock, symEnDly, sym2xEnDly, iqOut));
  endtask

  task automatic pulseError(input logic signed [7:0] pe);
    tick();
    errEn      = 1'b1;
    phaseError = pe;
    tick();
    errEn      = 1'b0;
    phaseError = '0;
    updateModel(pe);
  endtask

  task automatic randErrors(input int count);
    for (int n = 0; n < count; n++) begin
      rngState = lcgNext(rngState);
      pulseError(rngState[31:24]);
      checkModel();
    end
  endtask

  task automatic waitLock(input logic level, input int maxCycles);
    int n;
    n = 0;
    while (carrierLock !== level) begin
      if (n >= maxCycles) begin
        abortRun($sformatf("Timed out waiting for carrierLock to become %b", level));
      end else begin
        tick();
        n++;
      end
    end
  endtask

  // Four zero samples are already in flight when the stream starts
  task automatic runMixer(input int count);
    iqSample_t  expQ [$];
    logic [1:0] strQ [$];
    iqSample_t  inS;
    iqSample_t  expS;
    logic [1:0] strobes;
    logic [1:0] expStr;
    repeat (4) begin
      expQ.push_back('0);
      strQ.push_back(2'b00);
    end
    for (int n = 0; n < count + 4; n++) begin
      tick();
      expS   = expQ.pop_front();
      expStr = strQ.pop_front();
      assert (iqOut == expS)
        else valueError($sformatf("iqOut 0x%h, expected 0x%h", iqOut, expS));
      assert ({sym2xEnDly, symEnDly} == expStr)
        else valueError($sformatf("delayed strobes %b, expected %b",
                                  {sym2xEnDly, symEnDly}, expStr));
      assert (u_trellisCarrierLoop.freqWord == 32'd0)
        else valueError($sformatf("freqWord 0x%08h, expected zero",
                                  u_trellisCarrierLoop.freqWord));
      if (n < count) begin
        rngState = lcgNext(rngState);
        inS.i    = rngState[31:14];
        rngState = lcgNext(rngState);
        inS.q    = rngState[31:14];
        strobes  = rngState[13:12];
      end else begin
        inS     = '0;
        strobes = 2'b00;
      end
      iqIn               = inS;
      {sym2xEn, symEn}   = strobes;
      expS.i             = mixScale(inS.i);
      expS.q             = mixScale(inS.q);
      expQ.push_back(expS);
      strQ.push_back(strobes);
    end
  endtask

  task automatic runStep(input step_t st);
    case (st.op)
      OP_IDLE:     checkIdle();
      OP_WRITE:    writeReg(st.addr, st.lanes, st.data);
      OP_READ:     checkRead(st.addr, st.expVal);
      OP_RESET:    applyReset();
      OP_ERR: begin
        for (int n = 0; n < int'(st.count); n++) begin
          pulseError(st.data[7:0]);
          checkModel();
        end
      end
      OP_RANDERR:  randErrors(int'(st.count));
      OP_MIX:      runMixer(int'(st.count));
      OP_WAITLOCK: waitLock(st.data[0], int'(st.count));
      default:     abortRun("Unknown operation in the step table");
    endcase
  endtask

  initial begin
    rngState = 32'h7acb_7868;
    applyReset();
    for (int s = 0; s < NUM_STEPS; s++) begin
      runStep(STEPS[s]);
    end
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: trellisCarrierLoop.sv
//--------------------------------------------------------------------------
// Top level of the carrier recovery loop. Connects the host registers, the
// loop filter, the lock detector, the NCO and the complex mixer, and delays
// the symbol strobes by the 4-cycle mixer latency.
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module trellisCarrierLoop
  import carrierLoopPkg::*;
#(
  parameter logic [11:0] BASE_ADDR    = 12'h400,
  parameter int          SAMPLE_WIDTH = 18
)(
  input  logic              clk,
  input  logic              reset,
  input  logic              symEn,
  input  logic              sym2xEn,
  input  logic              errEn,
  input  logic signed [7:0] phaseError,
  input  iqSample_t         iqIn,
  input  regBus_t           bus,
  output logic [31:0]       dout,
  output iqSample_t         iqOut,
  output logic              carrierLock,
  output logic              symEnDly,
  output logic              sym2xEnDly
);

  loopCtrl_t       ctrl;
  logic [39:0]     lagAccum;
  logic [31:0]     freqWord;
  logic [15:0]     lockCounter;
  iqSample_t       lo;
  logic [3:0][1:0] strobeSr;

  loopRegs #(.BASE_ADDR(BASE_ADDR)) u_loopRegs (
    .clk, .reset, .bus,
    .lagAccum(lagAccum[39:8]),
    .lockCounter, .carrierLock,
    .ctrl, .dout
  );

  loopFilter u_loopFilter (
    .clk, .reset, .errEn, .phaseError, .ctrl,
    .lagAccum, .freqWord
  );

  lockDetector u_lockDetector (
    .clk, .reset, .errEn, .phaseError,
    .syncThreshold(ctrl.syncThreshold),
    .lockCount(ctrl.lockCount),
    .carrierLock, .lockCounter
  );

  carrierNco #(.SAMPLE_WIDTH(SAMPLE_WIDTH)) u_carrierNco (
    .clk, .reset, .freqWord, .lo
  );

  complexMixer #(.SAMPLE_WIDTH(SAMPLE_WIDTH)) u_complexMixer (
    .clk, .reset, .iqIn, .lo, .iqOut
  );

  // Strobe delay matching the mixer, bit 0 symEn and bit 1 sym2xEn
  always_ff @(posedge clk) begin
    if (reset) begin
      strobeSr <= '0;
    end else begin
      strobeSr <= {strobeSr[2:0], {sym2xEn, symEn}};
    end
  end

  assign symEnDly   = strobeSr[3][0];
  assign sym2xEnDly = strobeSr[3][1];

endmodule

`default_nettype wire
